/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ==========================================================================
// Fetch subsystem configuration
// ==========================================================================

// Data and address width
`define XLEN 32

// Instructions delivered to decode per pair
`define FETCH_WIDTH 2

// Direct-mapped BTB size
// Must stay a power of two, index bits are taken straight from the PC
`define BTB_ENTRIES 16

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 256

`endif

/* logic/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

  // One data word or byte address
  typedef logic [`XLEN-1:0] xword_t;

  // 2-bit saturating branch counter
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_state_t;

  // BTB index, pair address bits 3 and up
  typedef logic [$clog2(`BTB_ENTRIES)-1:0] btb_idx_t;

  // Pair address bits above the index
  typedef logic [`XLEN-4-$clog2(`BTB_ENTRIES):0] btb_tag_t;

  // Payload part of one BTB entry
  typedef struct packed {
    btb_tag_t tag;
    xword_t   target;
  } btb_entry_t;

  // Word index into instruction memory
  typedef logic [$clog2(`IMEM_WORDS)-1:0] imem_idx_t;

endpackage

/* logic/branch_predictor.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module branch_predictor
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  // Lookup port, same cycle answer
  input  xword_t lookup_pc,
  output logic   bp_hit,
  output logic   bp_taken,
  output xword_t bp_target,
  // Resolved branch from the branch unit
  input  logic   update_en,
  input  logic   update_taken,
  input  xword_t update_pc,
  input  xword_t update_target
);

  // Pair aligned, so bits 2:0 never index
  localparam int IDX_LSB = 3;
  localparam int TAG_LSB = IDX_LSB + $bits(btb_idx_t);

  // ==========================================================================
  // Entry storage
  // ==========================================================================

  // Valid bits and counters
  logic [`BTB_ENTRIES-1:0] valid_q;
  ctr_state_t              ctr_q   [`BTB_ENTRIES];
  // Tag and target per entry
  btb_entry_t              entry_q [`BTB_ENTRIES];

  btb_idx_t   look_idx;
  btb_tag_t   look_tag;
  btb_idx_t   upd_idx;
  btb_tag_t   upd_tag;
  logic       upd_hit;
  ctr_state_t upd_ctr;

  // One step toward the resolved direction, saturating at both ends
  function automatic ctr_state_t ctr_step(ctr_state_t cur, logic taken);
    ctr_state_t nxt;
    case (cur)
      strong_nt: nxt = taken ? weak_nt  : strong_nt;
      weak_nt:   nxt = taken ? weak_t   : strong_nt;
      weak_t:    nxt = taken ? strong_t : weak_nt;
      strong_t:  nxt = taken ? strong_t : weak_t;
      default:   nxt = weak_nt;
    endcase
    return nxt;
  endfunction

  // ==========================================================================
  // Lookup
  // ==========================================================================

  assign look_idx = lookup_pc[IDX_LSB +: $bits(btb_idx_t)];
  assign look_tag = lookup_pc[TAG_LSB +: $bits(btb_tag_t)];

  // Hit needs valid and matching tag
  assign bp_hit    = valid_q[look_idx] && (entry_q[look_idx].tag == look_tag);
  // Upper counter half predicts taken
  assign bp_taken  = (ctr_q[look_idx] == weak_t) || (ctr_q[look_idx] == strong_t);
  assign bp_target = entry_q[look_idx].target;

  // ==========================================================================
  // Update
  // ==========================================================================

  assign upd_idx = update_pc[IDX_LSB +: $bits(btb_idx_t)];
  assign upd_tag = update_pc[TAG_LSB +: $bits(btb_tag_t)];
  assign upd_hit = valid_q[upd_idx] && (entry_q[upd_idx].tag == upd_tag);

  // Fresh entry starts weak in the resolved direction
  assign upd_ctr = upd_hit ? ctr_step(ctr_q[upd_idx], update_taken)
                           : (update_taken ? weak_t : weak_nt);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= '0;
      for (int i = 0; i < `BTB_ENTRIES; i++) begin
        ctr_q[i] <= weak_nt;
      end
    end else if (update_en) begin
      valid_q[upd_idx] <= 1'b1;
      ctr_q[upd_idx]   <= upd_ctr;
    end
  end

  // Tag and target rewritten on every update
  always_ff @(posedge clk) begin
    if (update_en) begin
      entry_q[upd_idx] <= '{tag: upd_tag, target: update_target};
    end
  end

endmodule

/* logic/fetch.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch
  import core_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    fetch_en,
  input  logic                    stall,
  input  logic                    redirect_en,
  input  xword_t                  redirect_pc,
  input  logic                    flush_pipeline,
  input  xword_t                  flush_pc,
  // Prediction for the current PC
  input  logic                    bp_hit,
  input  logic                    bp_taken,
  input  xword_t                  bp_target,
  // Memory response
  input  logic                    imem_valid,
  input  xword_t                  imem_rdata0,
  input  xword_t                  imem_rdata1,
  input  xword_t                  imem_pc0,
  input  xword_t                  imem_pc1,
  // Predictor lookup and memory request
  output xword_t                  fetch_pc,
  output xword_t                  imem_addr0,
  output xword_t                  imem_addr1,
  output logic                    imem_ren,
  // Pair to decode
  output logic [`FETCH_WIDTH-1:0] if_valid,
  output xword_t                  if_pc0,
  output xword_t                  if_pc1,
  output xword_t                  if_instr0,
  output xword_t                  if_instr1
);

  xword_t pc_q;
  xword_t pc_d;
  // Redirect or flush, kills anything in flight
  logic   kill;

  // One pair parked while decode stalls
  logic   skid_valid_q;
  logic   skid_capture;
  xword_t skid_pc0_q;
  xword_t skid_pc1_q;
  xword_t skid_instr0_q;
  xword_t skid_instr1_q;

  // Output register load sources
  logic   load_skid;
  logic   load_resp;

  // ==========================================================================
  // PC and request
  // ==========================================================================

  assign kill = flush_pipeline || redirect_en;

  // Full skid blocks issue, no third pair in flight
  assign imem_ren   = fetch_en && !stall && !kill && !skid_valid_q;
  assign imem_addr0 = pc_q;
  assign imem_addr1 = pc_q + xword_t'(4);
  assign fetch_pc   = pc_q;

  // Flush beats redirect beats prediction
  always_comb begin
    if (flush_pipeline) begin
      pc_d = flush_pc;
    end else if (redirect_en) begin
      pc_d = redirect_pc;
    end else if (imem_ren && bp_hit && bp_taken) begin
      pc_d = bp_target;
    end else if (imem_ren) begin
      pc_d = pc_q + xword_t'(8);
    end else begin
      pc_d = pc_q;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_d;
    end
  end

  // ==========================================================================
  // Skid buffer
  // ==========================================================================

  // Stalled and empty parks the response
  // A full skid never sees a response, issue was blocked the cycle before
  assign skid_capture = !kill && imem_valid && stall && !skid_valid_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      skid_valid_q <= 1'b0;
    end else begin
      skid_valid_q <= !kill && (skid_capture || (stall && skid_valid_q));
    end
  end

  always_ff @(posedge clk) begin
    if (skid_capture) begin
      skid_pc0_q    <= imem_pc0;
      skid_pc1_q    <= imem_pc1;
      skid_instr0_q <= imem_rdata0;
      skid_instr1_q <= imem_rdata1;
    end
  end

  // ==========================================================================
  // Output register to decode
  // ==========================================================================

  // Parked pair is older, it goes first
  assign load_skid = !stall && !kill && skid_valid_q;
  assign load_resp = !stall && !kill && !skid_valid_q && imem_valid;

  // Stall holds the outputs even across a redirect, only flush clears them
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_valid <= '0;
    end else if (flush_pipeline) begin
      if_valid <= '0;
    end else if (!stall) begin
      if_valid <= {`FETCH_WIDTH{load_skid || load_resp}};
    end
  end

  always_ff @(posedge clk) begin
    if (load_skid) begin
      if_pc0    <= skid_pc0_q;
      if_pc1    <= skid_pc1_q;
      if_instr0 <= skid_instr0_q;
      if_instr1 <= skid_instr1_q;
    end else if (load_resp) begin
      if_pc0    <= imem_pc0;
      if_pc1    <= imem_pc1;
      if_instr0 <= imem_rdata0;
      if_instr1 <= imem_rdata1;
    end
  end

endmodule

/* logic/imem.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module imem
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // Pair read port
  input  logic      ren,
  input  xword_t    addr0,
  input  xword_t    addr1,
  output xword_t    rdata0,
  output xword_t    rdata1,
  output xword_t    rpc0,
  output xword_t    rpc1,
  output logic      rvalid,
  // Load port, one word per edge
  input  logic      load_en,
  input  imem_idx_t load_addr,
  input  xword_t    load_data
);

  xword_t    mem [`IMEM_WORDS];
  imem_idx_t idx0;
  imem_idx_t idx1;

  // Byte address to word index, upper bits dropped so it wraps
  assign idx0 = imem_idx_t'(addr0[`XLEN-1:2]);
  assign idx1 = imem_idx_t'(addr1[`XLEN-1:2]);

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // Data and the address it came from, one cycle after ren
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata0 <= mem[idx0];
      rdata1 <= mem[idx1];
      rpc0   <= addr0;
      rpc1   <= addr1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= ren;
    end
  end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_top
  import core_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  // Fetch control
  input  logic                    fetch_en,
  input  logic                    stall,
  input  logic                    redirect_en,
  input  xword_t                  redirect_pc,
  input  logic                    flush_pipeline,
  input  xword_t                  flush_pc,
  // Predictor training
  input  logic                    update_en,
  input  xword_t                  update_pc,
  input  logic                    update_taken,
  input  xword_t                  update_target,
  // Memory load
  input  logic                    load_en,
  input  imem_idx_t               load_addr,
  input  xword_t                  load_data,
  // Pair to decode
  output logic [`FETCH_WIDTH-1:0] if_valid,
  output xword_t                  if_pc0,
  output xword_t                  if_pc1,
  output xword_t                  if_instr0,
  output xword_t                  if_instr1
);

  // Lookup path
  xword_t fetch_pc;
  logic   bp_hit;
  logic   bp_taken;
  xword_t bp_target;

  // Memory path
  logic   imem_ren;
  xword_t imem_addr0;
  xword_t imem_addr1;
  logic   imem_valid;
  xword_t imem_rdata0;
  xword_t imem_rdata1;
  xword_t imem_pc0;
  xword_t imem_pc1;

  fetch u_fetch (
    .clk            (clk),
    .reset          (reset),
    .fetch_en       (fetch_en),
    .stall          (stall),
    .redirect_en    (redirect_en),
    .redirect_pc    (redirect_pc),
    .flush_pipeline (flush_pipeline),
    .flush_pc       (flush_pc),
    .bp_hit         (bp_hit),
    .bp_taken       (bp_taken),
    .bp_target      (bp_target),
    .imem_valid     (imem_valid),
    .imem_rdata0    (imem_rdata0),
    .imem_rdata1    (imem_rdata1),
    .imem_pc0       (imem_pc0),
    .imem_pc1       (imem_pc1),
    .fetch_pc       (fetch_pc),
    .imem_addr0     (imem_addr0),
    .imem_addr1     (imem_addr1),
    .imem_ren       (imem_ren),
    .if_valid       (if_valid),
    .if_pc0         (if_pc0),
    .if_pc1         (if_pc1),
    .if_instr0      (if_instr0),
    .if_instr1      (if_instr1)
  );

  // BTB looks up the live fetch PC
  branch_predictor u_bp (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (fetch_pc),
    .bp_hit        (bp_hit),
    .bp_taken      (bp_taken),
    .bp_target     (bp_target),
    .update_en     (update_en),
    .update_taken  (update_taken),
    .update_pc     (update_pc),
    .update_target (update_target)
  );

  imem u_imem (
    .clk       (clk),
    .reset     (reset),
    .ren       (imem_ren),
    .addr0     (imem_addr0),
    .addr1     (imem_addr1),
    .rdata0    (imem_rdata0),
    .rdata1    (imem_rdata1),
    .rpc0      (imem_pc0),
    .rpc1      (imem_pc1),
    .rvalid    (imem_valid),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

endmodule

/* verif/fetch_assertions.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_assertions
  import core_pkg::*;
(
  input logic                    clk,
  input logic                    reset,
  input logic                    stall,
  input logic                    redirect_en,
  input logic                    flush_pipeline,
  input logic                    imem_ren,
  input logic [`FETCH_WIDTH-1:0] if_valid,
  input xword_t                  if_pc0,
  input xword_t                  if_pc1,
  input xword_t                  if_instr0,
  input xword_t                  if_instr1
);

  // Count of failed assertions
  int unsigned fail_count = 0;

  // ==========================================================================
  // Output pair
  // ==========================================================================

  // Slots always travel together
  a_valid_pair: assert property (@(posedge clk) disable iff (reset)
    (&if_valid) || (if_valid == '0))
    else begin
      fail_count++;
      $error("if_valid slots disagree");
    end

  // Flush empties the output register at the next edge
  a_flush_clears: assert property (@(posedge clk) disable iff (reset)
    flush_pipeline |=> (if_valid == '0))
    else begin
      fail_count++;
      $error("if_valid still set in the cycle after a flush");
    end

  // Stall freezes what decode sees, flush excepted
  a_stall_holds_valid: assert property (@(posedge clk) disable iff (reset)
    (stall && !flush_pipeline) |=> $stable(if_valid))
    else begin
      fail_count++;
      $error("if_valid changed during a stall");
    end

  a_stall_holds_pair: assert property (@(posedge clk) disable iff (reset)
    (stall && !flush_pipeline && if_valid[0]) |=>
      ($stable(if_pc0) && $stable(if_pc1) && $stable(if_instr0) && $stable(if_instr1)))
    else begin
      fail_count++;
      $error("Pair on the outputs changed during a stall");
    end

  // ==========================================================================
  // Memory request
  // ==========================================================================

  // No request while decode holds or the path is being replaced
  a_no_issue_on_hold: assert property (@(posedge clk) disable iff (reset)
    (stall || redirect_en || flush_pipeline) |-> !imem_ren)
    else begin
      fail_count++;
      $error("imem_ren high during stall, redirect or flush");
    end

endmodule

/* verif/fetch_tb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_tb
  import core_pkg::*;
#(
  parameter int unsigned SEED = 93383
);

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_CYCLES   = 4000;
  localparam int IDX_BITS     = $clog2(`BTB_ENTRIES);
  // Reset, memory load and random traffic
  localparam int TOTAL_CYCLES = RESET_CYCLES + `IMEM_WORDS + NUM_CYCLES;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * CLK_PERIOD;

  logic                    clk;
  logic                    reset;
  logic                    fetch_en;
  logic                    stall;
  logic                    redirect_en;
  xword_t                  redirect_pc;
  logic                    flush_pipeline;
  xword_t                  flush_pc;
  logic                    update_en;
  xword_t                  update_pc;
  logic                    update_taken;
  xword_t                  update_target;
  logic                    load_en;
  imem_idx_t               load_addr;
  xword_t                  load_data;
  logic [`FETCH_WIDTH-1:0] if_valid;
  xword_t                  if_pc0;
  xword_t                  if_pc1;
  xword_t                  if_instr0;
  xword_t                  if_instr1;

  // ==========================================================================
  // Reference model state
  // ==========================================================================

  xword_t     mem_copy [`IMEM_WORDS];
  // BTB mirror
  logic       btb_v    [`BTB_ENTRIES];
  btb_tag_t   btb_tag  [`BTB_ENTRIES];
  xword_t     btb_tgt  [`BTB_ENTRIES];
  ctr_state_t btb_ctr  [`BTB_ENTRIES];
  // Issued pairs not yet handed to decode, oldest first
  xword_t     inflight_q [$];
  // Youngest queue entry is the response on the memory port this cycle
  logic       resp_live;
  xword_t     m_pc;
  logic       out_live;
  xword_t     out_pc;
  int         stall_left;
  int         idle_left;
  int         pairs_seen;

  fetch_top dut (
    .clk            (clk),
    .reset          (reset),
    .fetch_en       (fetch_en),
    .stall          (stall),
    .redirect_en    (redirect_en),
    .redirect_pc    (redirect_pc),
    .flush_pipeline (flush_pipeline),
    .flush_pc       (flush_pc),
    .update_en      (update_en),
    .update_pc      (update_pc),
    .update_taken   (update_taken),
    .update_target  (update_target),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .if_valid       (if_valid),
    .if_pc0         (if_pc0),
    .if_pc1         (if_pc1),
    .if_instr0      (if_instr0),
    .if_instr1      (if_instr1)
  );

  bind fetch fetch_assertions u_fetch_assertions (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall),
    .redirect_en    (redirect_en),
    .flush_pipeline (flush_pipeline),
    .imem_ren       (imem_ren),
    .if_valid       (if_valid),
    .if_pc0         (if_pc0),
    .if_pc1         (if_pc1),
    .if_instr0      (if_instr0),
    .if_instr1      (if_instr1)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired, the run did not finish in time");
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

  // Any bound assertion failure ends the run
  initial begin
    wait (dut.u_fetch.u_fetch_assertions.fail_count != 0);
    $display("An assertion on the fetch stage failed");
    $display("TEST FAIL");
    $fatal(1, "Assertion failure");
  end

  // ==========================================================================
  // Compare tasks
  // ==========================================================================

  task automatic check_pc(input string name, input xword_t exp, input xword_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "PC check failed");
    end
  endtask

  task automatic check_instr(input string name, input xword_t exp, input xword_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "Instruction check failed");
    end
  endtask

  task automatic check_valid(input string name, input logic [`FETCH_WIDTH-1:0] exp,
                             input logic [`FETCH_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "Valid check failed");
    end
  endtask

  // ==========================================================================
  // Model helpers
  // ==========================================================================

  // Pair aligned addresses in the first 1 KiB, a handful of BTB tags
  function automatic xword_t rand_pair_addr();
    return xword_t'(($urandom % 128) * 8);
  endfunction

  function automatic btb_idx_t pair_idx(input xword_t pc);
    return pc[3 +: IDX_BITS];
  endfunction

  function automatic btb_tag_t pair_tag(input xword_t pc);
    return pc[`XLEN-1 : 3 + IDX_BITS];
  endfunction

  function automatic imem_idx_t word_idx(input xword_t pc);
    return imem_idx_t'(pc >> 2);
  endfunction

  // Saturating count, 00 is strong not taken and 11 strong taken
  function automatic ctr_state_t ctr_next(input ctr_state_t cur, input logic taken);
    logic [1:0] v;
    v = cur;
    if (taken && v != 2'b11) begin
      v = v + 2'd1;
    end else if (!taken && v != 2'b00) begin
      v = v - 2'd1;
    end
    return ctr_state_t'(v);
  endfunction

  task automatic drive_inputs();
    load_en = 1'b0;
    // Stall bursts of 1 to 4 cycles
    if (stall_left == 0 && ($urandom % 8) == 0) begin
      stall_left = 1 + int'($urandom % 4);
    end
    stall = stall_left != 0;
    if (stall_left != 0) begin
      stall_left--;
    end
    // Occasional fetch_en gaps to drain the pipe
    if (idle_left == 0 && ($urandom % 64) == 0) begin
      idle_left = 2 + int'($urandom % 12);
    end
    fetch_en = idle_left == 0;
    if (idle_left != 0) begin
      idle_left--;
    end
    flush_pipeline = ($urandom % 60) == 0;
    flush_pc       = rand_pair_addr();
    // Half of the flushes come with a competing redirect
    redirect_en    = flush_pipeline ? (($urandom % 2) == 1) : (($urandom % 40) == 0);
    redirect_pc    = rand_pair_addr();
    // Training mostly aimed at the live fetch PC so lookups hit
    update_en      = ($urandom % 4) == 0;
    update_pc      = (($urandom % 2) == 0) ? m_pc : rand_pair_addr();
    update_taken   = ($urandom % 3) != 0;
    update_target  = rand_pair_addr();
  endtask

  // One clock edge of the fetch rules, using the inputs just driven
  task automatic step_model();
    logic     kill;
    logic     skid_full;
    logic     issue;
    logic     hit;
    btb_idx_t idx;
    btb_idx_t uidx;
    kill      = flush_pipeline || redirect_en;
    skid_full = inflight_q.size() > (resp_live ? 1 : 0);
    issue     = fetch_en && !stall && !kill && !skid_full;
    idx       = pair_idx(m_pc);
    hit       = btb_v[idx] && (btb_tag[idx] == pair_tag(m_pc));

    // Output register, a stall holds it unless flushed
    if (flush_pipeline) begin
      out_live = 1'b0;
    end else if (!stall) begin
      if (!kill && inflight_q.size() != 0) begin
        out_live = 1'b1;
        out_pc   = inflight_q.pop_front();
      end else begin
        out_live = 1'b0;
      end
    end
    if (kill) begin
      inflight_q.delete();
    end
    if (issue) begin
      inflight_q.push_back(m_pc);
    end
    resp_live = issue;

    // Next PC
    if (flush_pipeline) begin
      m_pc = flush_pc;
    end else if (redirect_en) begin
      m_pc = redirect_pc;
    end else if (issue && hit && (btb_ctr[idx] inside {weak_t, strong_t})) begin
      m_pc = btb_tgt[idx];
    end else if (issue) begin
      m_pc = m_pc + 32'd8;
    end

    // Training lands after the lookup of this cycle
    if (update_en) begin
      uidx = pair_idx(update_pc);
      if (btb_v[uidx] && (btb_tag[uidx] == pair_tag(update_pc))) begin
        btb_ctr[uidx] = ctr_next(btb_ctr[uidx], update_taken);
      end else begin
        btb_ctr[uidx] = update_taken ? weak_t : weak_nt;
      end
      btb_v[uidx]   = 1'b1;
      btb_tag[uidx] = pair_tag(update_pc);
      btb_tgt[uidx] = update_target;
    end
  endtask

  task automatic check_outputs(input int cyc);
    check_valid($sformatf("valid cycle %0d", cyc), {`FETCH_WIDTH{out_live}}, if_valid);
    if (out_live) begin
      check_pc($sformatf("pc0 cycle %0d", cyc), out_pc, if_pc0);
      check_pc($sformatf("pc1 cycle %0d", cyc), out_pc + 32'd4, if_pc1);
      check_instr($sformatf("instr0 cycle %0d", cyc), mem_copy[word_idx(out_pc)], if_instr0);
      check_instr($sformatf("instr1 cycle %0d", cyc),
                  mem_copy[word_idx(out_pc + 32'd4)], if_instr1);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    int cyc;
    int i;
    reset          = 1'b1;
    fetch_en       = 1'b0;
    stall          = 1'b0;
    redirect_en    = 1'b0;
    redirect_pc    = '0;
    flush_pipeline = 1'b0;
    flush_pc       = '0;
    update_en      = 1'b0;
    update_pc      = '0;
    update_taken   = 1'b0;
    update_target  = '0;
    load_en        = 1'b0;
    load_addr      = '0;
    load_data      = '0;
    void'($urandom(SEED));

    // Model starts where reset leaves the DUT
    m_pc       = '0;
    resp_live  = 1'b0;
    out_live   = 1'b0;
    out_pc     = '0;
    stall_left = 0;
    idle_left  = 0;
    pairs_seen = 0;
    for (i = 0; i < `BTB_ENTRIES; i++) begin
      btb_v[i] = 1'b0;
    end

    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_valid("in reset", '0, if_valid);
    end
    reset = 1'b0;

    // Fill memory through the load port, fetch still disabled
    for (i = 0; i < `IMEM_WORDS; i++) begin
      load_en     = 1'b1;
      load_addr   = imem_idx_t'(i);
      load_data   = $urandom;
      mem_copy[i] = load_data;
      @(negedge clk);
      check_valid("after reset", '0, if_valid);
    end

    for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      check_outputs(cyc);
      if (out_live) begin
        pairs_seen++;
      end
      drive_inputs();
      step_model();
      @(negedge clk);
    end
    check_outputs(NUM_CYCLES);

    $display("Checked %0d cycles, %0d output cycles with a valid pair", NUM_CYCLES,
             pairs_seen);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
logic/core_pkg.sv
logic/branch_predictor.sv
logic/fetch.sv
logic/imem.sv
logic/fetch_top.sv
verif/fetch_assertions.sv
verif/fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch subsystem testbench
# Override any variable on the command line, e.g. make sim SEED=1234

VERILATOR ?= verilator
TOP       ?= fetch_tb
SEED      ?= 93383
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | grep "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
